//--- verilog/y86Pkg.sv
package y86Pkg;

    localparam int NUM_REGS = 15;

    typedef logic [3:0] regId_t;

    localparam regId_t REG_RSP  = 4'h4;  // stack pointer
    localparam regId_t REG_NONE = 4'hf;  // no register

    // codes 12 to 15 are invalid
    typedef enum logic [3:0] {
        IHALT   = 4'h0,
        INOP    = 4'h1,
        IRRMOVQ = 4'h2,
        IIRMOVQ = 4'h3,
        IRMMOVQ = 4'h4,
        IMRMOVQ = 4'h5,
        IOPQ    = 4'h6,
        IJXX    = 4'h7,
        ICALL   = 4'h8,
        IRET    = 4'h9,
        IPUSHQ  = 4'ha,
        IPOPQ   = 4'hb
    } icode_e;

    typedef enum logic [2:0] {
        STAT_OK     = 3'd0,
        STAT_RESET  = 3'd1,
        STAT_BUBBLE = 3'd2,
        STAT_STALL  = 3'd3
    } stat_e;

    // fetch-to-decode record
    typedef struct packed {
        stat_e       stat;
        icode_e      icode;
        logic [3:0]  ifun;
        regId_t      rA;
        regId_t      rB;
        logic [63:0] valC;
        logic [63:0] valP;
    } fetchD_t;

    // write-back request, ports E and M
    typedef struct packed {
        regId_t      dstE;
        logic [63:0] valE;
        regId_t      dstM;
        logic [63:0] valM;
    } wbWrite_t;

    // decode-to-execute record
    typedef struct packed {
        stat_e       stat;
        icode_e      icode;
        logic [3:0]  ifun;
        logic [63:0] valA;
        logic [63:0] valB;
        logic [63:0] valC;
        regId_t      dstE;
        regId_t      dstM;
        regId_t      srcA;
        regId_t      srcB;
    } decodeE_t;

endpackage

//--- verilog/pipeRegD.sv
`timescale 1ns/1ps

module pipeRegD (
    input  logic            stall_i,
    input  logic            rst_n_i,
    input  logic            holdD_i,
    input  logic            bubbleD_i,
    input  y86Pkg::fetchD_t fetch_i,
    output y86Pkg::fetchD_t regD_o
);
    import y86Pkg::*;

    // empty slot, tagged with why it is empty
    function automatic fetchD_t nopRecord(input stat_e tag);
        fetchD_t rec;
        rec       = '0;
        rec.stat  = tag;
        rec.icode = INOP;
        rec.rA    = REG_NONE;
        rec.rB    = REG_NONE;
        return rec;
    endfunction

    always_ff @(posedge stall_i) begin
        if (!rst_n_i) begin
            regD_o <= nopRecord(STAT_RESET);
        end else if (holdD_i) begin
            regD_o.stat <= STAT_STALL;  // payload stays put
        end else if (bubbleD_i) begin
            regD_o <= nopRecord(STAT_BUBBLE);
        end else begin
            regD_o      <= fetch_i;
            regD_o.stat <= STAT_OK;
        end
    end

endmodule

//--- verilog/regIdDecode.sv
`timescale 1ns/1ps

module regIdDecode (
    input  y86Pkg::icode_e icode_i,
    input  y86Pkg::regId_t rA_i,
    input  y86Pkg::regId_t rB_i,
    output y86Pkg::regId_t srcA_o,
    output y86Pkg::regId_t srcB_o,
    output y86Pkg::regId_t dstE_o,
    output y86Pkg::regId_t dstM_o
);
    import y86Pkg::*;

    always_comb begin
        srcA_o = REG_NONE;  // halt, nop, jxx and invalid codes
        srcB_o = REG_NONE;
        dstE_o = REG_NONE;
        dstM_o = REG_NONE;
        case (icode_i)
            IRRMOVQ: begin
                srcA_o = rA_i;
                dstE_o = rB_i;
            end
            IIRMOVQ: begin
                dstE_o = rB_i;
            end
            IRMMOVQ: begin
                srcA_o = rA_i;
                srcB_o = rB_i;
            end
            IMRMOVQ: begin
                srcB_o = rB_i;  // base address
                dstM_o = rA_i;
            end
            IOPQ: begin
                srcA_o = rA_i;
                srcB_o = rB_i;
                dstE_o = rB_i;
            end
            ICALL: begin
                srcB_o = REG_RSP;
                dstE_o = REG_RSP;
            end
            IRET: begin
                srcA_o = REG_RSP;
                srcB_o = REG_RSP;
                dstE_o = REG_RSP;
            end
            IPUSHQ: begin
                srcA_o = rA_i;
                srcB_o = REG_RSP;
                dstE_o = REG_RSP;
            end
            IPOPQ: begin
                srcA_o = REG_RSP;
                srcB_o = REG_RSP;
                dstE_o = REG_RSP;
                dstM_o = rA_i;  // loaded value
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic             stall_i,
    input  logic             rst_n_i,
    input  y86Pkg::regId_t   srcA_i,
    input  y86Pkg::regId_t   srcB_i,
    input  y86Pkg::wbWrite_t wb_i,
    output logic [63:0]      valA_o,
    output logic [63:0]      valB_o
);
    import y86Pkg::*;

    logic [63:0] regs [NUM_REGS];

    // read with same-cycle bypass, M ahead of E
    function automatic logic [63:0] readPort(input regId_t addr);
        logic [63:0] val;
        if (addr == REG_NONE) begin
            val = '0;
        end else if (addr == wb_i.dstM) begin
            val = wb_i.valM;
        end else if (addr == wb_i.dstE) begin
            val = wb_i.valE;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge stall_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_i.dstE != REG_NONE) begin
                regs[wb_i.dstE] <= wb_i.valE;
            end
            if (wb_i.dstM != REG_NONE) begin
                regs[wb_i.dstM] <= wb_i.valM;  // last write wins on a clash
            end
        end
    end

    always_comb begin
        valA_o = readPort(srcA_i);
        valB_o = readPort(srcB_i);
    end

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic             stall_i,
    input  logic             rst_n_i,
    input  y86Pkg::fetchD_t  regD_i,
    input  y86Pkg::wbWrite_t wb_i,
    output y86Pkg::decodeE_t dec_o
);
    import y86Pkg::*;

    regId_t      srcA;
    regId_t      srcB;
    regId_t      dstE;
    regId_t      dstM;
    logic [63:0] rdA;
    logic [63:0] rdB;

    regIdDecode regIdDecode_inst (
        .icode_i (regD_i.icode),
        .rA_i    (regD_i.rA),
        .rB_i    (regD_i.rB),
        .srcA_o  (srcA),
        .srcB_o  (srcB),
        .dstE_o  (dstE),
        .dstM_o  (dstM)
    );

    regFile regFile_inst (
        .stall_i (stall_i),
        .rst_n_i (rst_n_i),
        .srcA_i  (srcA),
        .srcB_i  (srcB),
        .wb_i    (wb_i),
        .valA_o  (rdA),
        .valB_o  (rdB)
    );

    always_comb begin
        dec_o.stat  = regD_i.stat;
        dec_o.icode = regD_i.icode;
        dec_o.ifun  = regD_i.ifun;
        dec_o.valC  = regD_i.valC;
        // call and jump carry the fall-through address
        dec_o.valA  = (regD_i.icode == ICALL || regD_i.icode == IJXX) ? regD_i.valP : rdA;
        dec_o.valB  = rdB;
        dec_o.dstE  = dstE;
        dec_o.dstM  = dstM;
        dec_o.srcA  = srcA;
        dec_o.srcB  = srcB;
    end

endmodule

//--- verilog/y86DecodeTop.sv
`timescale 1ns/1ps

module y86DecodeTop (
    input  logic             stall_i,
    input  logic             rst_n_i,
    input  logic             holdD_i,
    input  logic             bubbleD_i,
    input  y86Pkg::fetchD_t  fetch_i,
    input  y86Pkg::wbWrite_t wb_i,
    output y86Pkg::decodeE_t dec_o
);
    import y86Pkg::*;

    fetchD_t regD;  // registered instruction

    pipeRegD pipeRegD_inst (
        .stall_i   (stall_i),
        .rst_n_i   (rst_n_i),
        .holdD_i   (holdD_i),
        .bubbleD_i (bubbleD_i),
        .fetch_i   (fetch_i),
        .regD_o    (regD)
    );

    decodeStage decodeStage_inst (
        .stall_i (stall_i),
        .rst_n_i (rst_n_i),
        .regD_i  (regD),
        .wb_i    (wb_i),
        .dec_o   (dec_o)
    );

endmodule

//--- dv/decodeStage_assertions.sv
`timescale 1ns/1ps

module decodeStage_assertions (
    input logic             stall_i,
    input logic             rst_n_i,
    input logic             holdD_i,
    input logic             bubbleD_i,
    input y86Pkg::decodeE_t dec_i
);
    import y86Pkg::*;

    // an empty source reads as zero unless valP takes the slot
    property noneReadsZero;
        @(posedge stall_i) disable iff (!rst_n_i)
            (dec_i.srcA == REG_NONE && !(dec_i.icode inside {ICALL, IJXX})) |-> dec_i.valA == 64'd0;
    endproperty

    property idleWritesNothing;
        @(posedge stall_i) disable iff (!rst_n_i)
            (dec_i.icode inside {IHALT, INOP})
                |-> (dec_i.dstE == REG_NONE && dec_i.dstM == REG_NONE);
    endproperty

    property bubbleMarked;
        @(posedge stall_i) disable iff (!rst_n_i)
            (bubbleD_i && !holdD_i) |=> dec_i.stat == STAT_BUBBLE;
    endproperty

    assert property (noneReadsZero) else $error("valA is not zero for an empty source");
    assert property (idleWritesNothing) else $error("halt or nop names a destination");
    assert property (bubbleMarked) else $error("bubble did not produce a bubble record");

endmodule

bind y86DecodeTop decodeStage_assertions decodeStage_assertions_inst (
    .stall_i   (stall_i),
    .rst_n_i   (rst_n_i),
    .holdD_i   (holdD_i),
    .bubbleD_i (bubbleD_i),
    .dec_i     (dec_o)
);

//--- dv/tbDecode.sv
`timescale 1ns/1ps

module tbDecode;
    import y86Pkg::*;

    logic     stall_i;
    logic     rst_n_i;
    logic     holdD;
    logic     bubbleD;
    fetchD_t  fetch;
    wbWrite_t wb;
    decodeE_t dec;

    logic [63:0] modelRegs [NUM_REGS];
    fetchD_t     modelD;
    bit          modelValid;
    decodeE_t    expRec;
    string       testName;

    y86DecodeTop y86DecodeTop_inst (
        .stall_i   (stall_i),
        .rst_n_i   (rst_n_i),
        .holdD_i   (holdD),
        .bubbleD_i (bubbleD),
        .fetch_i   (fetch),
        .wb_i      (wb),
        .dec_o     (dec)
    );

    initial begin
        stall_i = 1'b0;
        forever #50 stall_i = ~stall_i;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkDecode(input string name, input decodeE_t expVal, input decodeE_t actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("Fail %s expected %h actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkStat(input string name, input stat_e expVal, input stat_e actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("Fail %s expected %s actual %s", name, expVal.name(), actVal.name()));
        end
    endtask

    // {srcA, srcB, dstE, dstM} straight from the instruction set
    function automatic logic [15:0] idTable(input icode_e ic, input regId_t ra, input regId_t rb);
        case (ic)
            IRRMOVQ: return {ra, REG_NONE, rb, REG_NONE};
            IIRMOVQ: return {REG_NONE, REG_NONE, rb, REG_NONE};
            IRMMOVQ: return {ra, rb, REG_NONE, REG_NONE};
            IMRMOVQ: return {REG_NONE, rb, REG_NONE, ra};
            IOPQ:    return {ra, rb, rb, REG_NONE};
            ICALL:   return {REG_NONE, REG_RSP, REG_RSP, REG_NONE};
            IRET:    return {REG_RSP, REG_RSP, REG_RSP, REG_NONE};
            IPUSHQ:  return {ra, REG_RSP, REG_RSP, REG_NONE};
            IPOPQ:   return {REG_RSP, REG_RSP, REG_RSP, ra};
            default: return {4{REG_NONE}};
        endcase
    endfunction

    function automatic logic [63:0] modelRead(input regId_t addr, input wbWrite_t w);
        if (addr == REG_NONE) return 64'd0;
        if (addr == w.dstM) return w.valM;  // M beats E
        if (addr == w.dstE) return w.valE;
        return modelRegs[addr];
    endfunction

    function automatic decodeE_t expDecode(input fetchD_t d, input wbWrite_t w);
        decodeE_t    e;
        logic [15:0] ids;
        ids     = idTable(d.icode, d.rA, d.rB);
        e.stat  = d.stat;
        e.icode = d.icode;
        e.ifun  = d.ifun;
        e.valC  = d.valC;
        e.srcA  = ids[15:12];
        e.srcB  = ids[11:8];
        e.dstE  = ids[7:4];
        e.dstM  = ids[3:0];
        e.valA  = (d.icode inside {ICALL, IJXX}) ? d.valP : modelRead(e.srcA, w);
        e.valB  = modelRead(e.srcB, w);
        return e;
    endfunction

    function automatic fetchD_t nopD(input stat_e s);
        fetchD_t n;
        n       = '0;
        n.stat  = s;
        n.icode = INOP;
        n.rA    = REG_NONE;
        n.rB    = REG_NONE;
        return n;
    endfunction

    function automatic fetchD_t makeFetch(input icode_e ic, input regId_t ra, input regId_t rb,
                                          input logic [63:0] vc, input logic [63:0] vp);
        fetchD_t f;
        f.stat  = STAT_OK;
        f.icode = ic;
        f.ifun  = 4'h1;
        f.rA    = ra;
        f.rB    = rb;
        f.valC  = vc;
        f.valP  = vp;
        return f;
    endfunction

    function automatic wbWrite_t makeWb(input regId_t de, input logic [63:0] ve,
                                        input regId_t dm, input logic [63:0] vm);
        wbWrite_t w;
        w.dstE = de;
        w.valE = ve;
        w.dstM = dm;
        w.valM = vm;
        return w;
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    // mirror of the next edge, taken from the live inputs
    task automatic updateModel();
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) modelRegs[i] = 64'd0;
            modelD     = nopD(STAT_RESET);
            modelValid = 1'b1;
        end else begin
            if (wb.dstE != REG_NONE) modelRegs[wb.dstE] = wb.valE;
            if (wb.dstM != REG_NONE) modelRegs[wb.dstM] = wb.valM;
            if (holdD) begin
                modelD.stat = STAT_STALL;
            end else if (bubbleD) begin
                modelD = nopD(STAT_BUBBLE);
            end else begin
                modelD      = fetch;
                modelD.stat = STAT_OK;
            end
        end
    endtask

    initial begin
        modelValid = 1'b0;
        forever begin
            @(negedge stall_i);
            #40;  // just ahead of the rising edge
            if (modelValid) begin
                expRec = expDecode(modelD, wb);
                checkStat(testName, expRec.stat, dec.stat);
                checkDecode(testName, expRec, dec);
            end
            updateModel();
        end
    end

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (dec.stat !== STAT_RESET) begin
            if (cycles == 10) failRun("timeout: decode output never showed the reset status");
            @(negedge stall_i);
            cycles++;
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(negedge stall_i);
    endtask

    initial begin
        logic [31:0] r;
        decodeE_t    resetRec;
        void'($urandom(50531));
        testName = "reset";
        rst_n_i  = 1'b0;
        holdD    = 1'b0;
        bubbleD  = 1'b0;
        fetch    = nopD(STAT_OK);
        wb       = makeWb(REG_NONE, 64'd0, REG_NONE, 64'd0);
        step(5);
        rst_n_i = 1'b1;
        waitForReset();
        resetRec       = '0;  // empty nop slot, registers cleared
        resetRec.stat  = STAT_RESET;
        resetRec.icode = INOP;
        resetRec.srcA  = REG_NONE;
        resetRec.srcB  = REG_NONE;
        resetRec.dstE  = REG_NONE;
        resetRec.dstM  = REG_NONE;
        checkDecode("reset", resetRec, dec);

        testName = "preload";
        for (int i = 0; i < NUM_REGS; i++) begin
            wb = makeWb(i[3:0], {4{i[3:0], 12'h5a3}}, REG_NONE, 64'd0);
            step(1);
        end
        wb = makeWb(REG_NONE, 64'd0, REG_NONE, 64'd0);

        testName = "idTable";
        for (int c = 0; c < 13; c++) begin
            fetch = makeFetch(icode_e'(c[3:0]), 4'h3, 4'h7, 64'h77 + 64'(c), 64'h400 + 64'(c * 9));
            step(1);
        end

        testName = "bypass";
        fetch = makeFetch(IOPQ, 4'h3, 4'h7, 64'd0, 64'h500);
        step(1);
        wb = makeWb(4'h3, 64'haaaa_0000_1111_2222, 4'h2, 64'h1234);
        step(2);
        testName = "mWins";
        wb = makeWb(4'h7, 64'h1, 4'h7, 64'h2);
        step(1);
        wb = makeWb(REG_NONE, 64'd0, REG_NONE, 64'd0);
        step(1);
        testName = "noneDst";
        wb    = makeWb(REG_NONE, 64'hdead, REG_NONE, 64'hbeef);
        fetch = makeFetch(IRRMOVQ, REG_NONE, 4'h5, 64'd0, 64'h600);
        step(2);

        testName = "hold";
        fetch = makeFetch(IPUSHQ, 4'h6, 4'h1, 64'h99, 64'h700);
        step(1);
        holdD = 1'b1;
        wb    = makeWb(REG_RSP, 64'h8000, 4'h6, 64'h66);  // writes go on during hold
        fetch = makeFetch(ICALL, 4'h2, 4'h2, 64'h11, 64'h800);
        step(2);
        testName = "bubble";
        holdD   = 1'b0;
        bubbleD = 1'b1;
        wb      = makeWb(4'h9, 64'h9999, REG_NONE, 64'd0);
        step(1);
        testName = "holdAndBubble";
        holdD = 1'b1;
        step(1);
        holdD   = 1'b0;
        bubbleD = 1'b0;
        step(1);

        testName = "random";
        for (int i = 0; i < 2000; i++) begin
            r       = $urandom();
            holdD   = (r[2:0] == 3'd0);
            bubbleD = (r[5:3] == 3'd0);
            fetch   = makeFetch(icode_e'(r[9:6]), r[13:10], r[17:14], rand64(), rand64());
            fetch.ifun = r[31:28];
            wb      = makeWb(r[21:18], rand64(), r[25:22], rand64());
            if (r[26]) wb.dstE = REG_NONE;  // port idle
            if (r[27]) wb.dstM = REG_NONE;
            step(1);
        end

        testName = "drain";
        holdD    = 1'b0;
        bubbleD  = 1'b0;
        wb       = makeWb(REG_NONE, 64'd0, REG_NONE, 64'd0);
        step(2);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src.f
verilog/y86Pkg.sv
verilog/pipeRegD.sv
verilog/regIdDecode.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/y86DecodeTop.sv
dv/decodeStage_assertions.sv
dv/tbDecode.sv

//--- run.sh
#!/bin/sh
# build and run the decode-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tbDecode -f src.f -o simDecode

./obj_dir/simDecode > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
